//--- verilog/sd_pkg.sv
package sd_pkg;

  // card clock dividers, system clocks per half period
  localparam logic [7:0] DIV_SLOW_HALF = 8'd125;
  localparam logic [7:0] DIV_FAST_HALF = 8'd2;

  // slow card clocks with chip select high before CMD0
  localparam logic [6:0] POWERUP_CLOCKS = 7'd80;
  localparam logic [3:0] RETRY_LIMIT = 4'd10;
  localparam logic [7:0] RESP_TIMEOUT_BITS = 8'd100;

  localparam logic [5:0] FRAME_BITS = 6'd48;
  localparam logic [5:0] R1_BITS = 6'd8;
  localparam logic [5:0] R7_BITS = 6'd40;

  // command indices
  localparam logic [5:0] CMD_GO_IDLE = 6'd0;
  localparam logic [5:0] CMD_SEND_IF_COND = 6'd8;
  localparam logic [5:0] CMD_APP_CMD = 6'd55;
  localparam logic [5:0] CMD_SD_SEND_OP_COND = 6'd41;
  localparam logic [5:0] CMD_READ_OCR = 6'd58;

  // 2.7-3.6 V range plus check pattern
  localparam logic [31:0] ARG_IF_COND = 32'h0000_01AA;
  localparam logic [31:0] ARG_HCS = 32'h4000_0000;

  localparam logic [7:0] R1_IDLE = 8'h01;
  localparam logic [7:0] R1_READY = 8'h00;
  localparam logic [7:0] R1_ILLEGAL_IDLE = 8'h05;

  typedef struct packed {
    logic [1:0]  start;
    logic [5:0]  index;
    logic [31:0] arg;
    logic [6:0]  crc;
    logic        stop;
  } sd_frame_s;

  // same 48 bits, as fields or as the shift vector
  typedef union packed {
    sd_frame_s   fields;
    logic [47:0] raw;
  } sd_frame_u;

  typedef struct packed {
    logic [7:0]  r1;
    logic [31:0] tail;
  } sd_resp_s;

  typedef struct packed {
    sd_frame_u frame;
    logic      long_resp;
  } sd_cmd_req_s;

endpackage

//--- verilog/sd_clk_gen.sv
`timescale 1ns/1ps

module sd_clk_gen import sd_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic fast_sel,
  output logic sd_sclk,
  output logic sclk_rise,
  output logic sclk_fall
);

  logic [7:0] half_q;
  logic [7:0] cnt_q;
  logic       edge_hit;

  assign edge_hit = (cnt_q == half_q - 8'd1);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      half_q    <= DIV_SLOW_HALF;
      cnt_q     <= 8'd0;
      sd_sclk   <= 1'b0;
      sclk_rise <= 1'b0;
      sclk_fall <= 1'b0;
    end else begin
      // strobes line up with the toggle of sd_sclk
      sclk_rise <= edge_hit && !sd_sclk;
      sclk_fall <= edge_hit && sd_sclk;
      if (edge_hit) begin
        cnt_q   <= 8'd0;
        sd_sclk <= ~sd_sclk;
        // new rate only takes effect at a half period boundary
        half_q  <= fast_sel ? DIV_FAST_HALF : DIV_SLOW_HALF;
      end else begin
        cnt_q <= cnt_q + 8'd1;
      end
    end
  end

endmodule

//--- verilog/sd_cmd_engine.sv
`timescale 1ns/1ps

module sd_cmd_engine import sd_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        sclk_rise,
  input  logic        sclk_fall,
  input  logic        cmd_start,
  input  sd_cmd_req_s cmd_req,
  input  logic        sd_miso,
  output logic        sd_mosi,
  output logic        cmd_done,
  output logic        resp_timeout,
  output sd_resp_s    resp
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SEND,
    ST_WAIT,
    ST_RECV
  } eng_state_e;

  eng_state_e  state;
  sd_frame_u   frame_q;
  logic        long_q;
  logic [6:0]  crc_q;
  logic [6:0]  crc_next;
  logic        crc_fb;
  logic [5:0]  bit_cnt;
  logic [7:0]  to_cnt;
  logic [39:0] rx_sh;
  logic [39:0] rx_next;
  logic [5:0]  rx_len;
  logic        rx_last;
  logic        to_hit;

  // crc7, x^7 + x^3 + 1
  assign crc_fb   = frame_q.raw[47] ^ crc_q[6];
  assign crc_next = {crc_q[5:0], 1'b0} ^ (crc_fb ? 7'h09 : 7'h00);

  assign rx_next = {rx_sh[38:0], sd_miso};
  assign rx_len  = long_q ? R7_BITS : R1_BITS;
  assign rx_last = (state == ST_RECV) && sclk_rise && (bit_cnt == rx_len - 6'd1);
  assign to_hit  = (state == ST_WAIT) && sclk_rise && sd_miso &&
                   (to_cnt == RESP_TIMEOUT_BITS - 8'd1);

  // frame, crc and response shifters
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && cmd_start) begin
      frame_q <= cmd_req.frame;
      long_q  <= cmd_req.long_resp;
      crc_q   <= 7'd0;
    end else if (state == ST_SEND && sclk_fall) begin
      if (bit_cnt < FRAME_BITS - 6'd8) begin
        crc_q <= crc_next;
      end
      if (bit_cnt == FRAME_BITS - 6'd9) begin
        // last payload bit out, drop crc and stop bit in behind it
        frame_q.raw[47:40] <= {crc_next, 1'b1};
      end else begin
        frame_q.raw <= {frame_q.raw[46:0], 1'b1};
      end
    end
    if (sclk_rise && (state == ST_WAIT || state == ST_RECV)) begin
      rx_sh <= rx_next;
    end
    if (rx_last) begin
      resp.r1   <= rx_next[7:0];
      resp.tail <= long_q ? rx_next[31:0] : 32'hFFFF_FFFF;
      if (long_q) begin
        resp.r1 <= rx_next[39:32];
      end
    end else if (to_hit) begin
      resp <= '1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state        <= ST_IDLE;
      bit_cnt      <= 6'd0;
      to_cnt       <= 8'd0;
      sd_mosi      <= 1'b1;
      cmd_done     <= 1'b0;
      resp_timeout <= 1'b0;
    end else begin
      cmd_done <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (cmd_start) begin
            bit_cnt <= 6'd0;
            state   <= ST_SEND;
          end
        end
        ST_SEND: begin
          if (sclk_fall) begin
            sd_mosi <= frame_q.raw[47];
            if (bit_cnt == FRAME_BITS - 6'd1) begin
              to_cnt <= 8'd0;
              state  <= ST_WAIT;
            end else begin
              bit_cnt <= bit_cnt + 6'd1;
            end
          end
        end
        ST_WAIT: begin
          if (to_hit) begin
            resp_timeout <= 1'b1;
            cmd_done     <= 1'b1;
            state        <= ST_IDLE;
          end else if (sclk_rise && !sd_miso) begin
            // start bit is the msb of r1
            bit_cnt <= 6'd1;
            state   <= ST_RECV;
          end else if (sclk_rise) begin
            to_cnt <= to_cnt + 8'd1;
          end
        end
        ST_RECV: begin
          if (rx_last) begin
            resp_timeout <= 1'b0;
            cmd_done     <= 1'b1;
            state        <= ST_IDLE;
          end else if (sclk_rise) begin
            bit_cnt <= bit_cnt + 6'd1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

//--- verilog/sd_init_fsm.sv
`timescale 1ns/1ps

module sd_init_fsm import sd_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        sclk_rise,
  input  logic        cmd_done,
  input  logic        resp_timeout,
  input  sd_resp_s    resp,
  output logic        cmd_start,
  output sd_cmd_req_s cmd_req,
  output logic        sd_cs_n,
  output logic        fast_sel,
  output logic        init_done,
  output logic        init_error,
  output logic        card_hc,
  output logic        card_v1
);

  typedef enum logic [3:0] {
    S_PWRUP,
    S_CMD0,
    S_CMD8,
    S_OCR1,
    S_APP,
    S_OPCOND,
    S_OCR2,
    S_DONE,
    S_ERROR
  } step_e;

  step_e      step;
  logic       busy;
  logic [6:0] pwr_cnt;
  logic [3:0] retry_cnt;
  logic       retry_last;

  assign retry_last = (retry_cnt == RETRY_LIMIT - 4'd1);

  // crc field stays zero, the engine fills it in
  always_comb begin
    cmd_req = '0;
    cmd_req.frame.fields.start = 2'b01;
    cmd_req.frame.fields.stop  = 1'b1;
    case (step)
      S_CMD8: begin
        cmd_req.frame.fields.index = CMD_SEND_IF_COND;
        cmd_req.frame.fields.arg   = ARG_IF_COND;
        cmd_req.long_resp          = 1'b1;
      end
      S_OCR1, S_OCR2: begin
        cmd_req.frame.fields.index = CMD_READ_OCR;
        cmd_req.long_resp          = 1'b1;
      end
      S_APP: cmd_req.frame.fields.index = CMD_APP_CMD;
      S_OPCOND: begin
        cmd_req.frame.fields.index = CMD_SD_SEND_OP_COND;
        cmd_req.frame.fields.arg   = ARG_HCS;
      end
      default: cmd_req.frame.fields.index = CMD_GO_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      step       <= S_PWRUP;
      busy       <= 1'b0;
      cmd_start  <= 1'b0;
      pwr_cnt    <= 7'd0;
      retry_cnt  <= 4'd0;
      sd_cs_n    <= 1'b1;
      fast_sel   <= 1'b0;
      init_done  <= 1'b0;
      init_error <= 1'b0;
      card_hc    <= 1'b0;
      card_v1    <= 1'b0;
    end else begin
      cmd_start <= 1'b0;
      case (step)
        S_PWRUP: begin
          if (sclk_rise) begin
            if (pwr_cnt == POWERUP_CLOCKS - 7'd1) begin
              sd_cs_n <= 1'b0;
              step    <= S_CMD0;
            end else begin
              pwr_cnt <= pwr_cnt + 7'd1;
            end
          end
        end
        S_DONE: begin
          fast_sel  <= 1'b1;
          init_done <= 1'b1;
        end
        S_ERROR: init_error <= 1'b1;
        default: begin
          if (!busy) begin
            cmd_start <= 1'b1;
            busy      <= 1'b1;
          end else if (cmd_done) begin
            busy <= 1'b0;
            case (step)
              S_CMD0: begin
                if (resp_timeout || resp.r1 != R1_IDLE) begin
                  if (retry_last) begin
                    step <= S_ERROR;
                  end else begin
                    retry_cnt <= retry_cnt + 4'd1;
                  end
                end else begin
                  retry_cnt <= 4'd0;
                  step      <= S_CMD8;
                end
              end
              S_CMD8: begin
                if (resp_timeout) begin
                  step <= S_ERROR;
                end else if (resp.r1 == R1_ILLEGAL_IDLE) begin
                  // v1 card does not know CMD8
                  card_v1 <= 1'b1;
                  step    <= S_OCR1;
                end else if (resp.r1 == R1_IDLE && resp.tail[11:0] == ARG_IF_COND[11:0]) begin
                  step <= S_OCR1;
                end else begin
                  step <= S_ERROR;
                end
              end
              S_OCR1: begin
                step <= (!resp_timeout && resp.r1 == R1_IDLE) ? S_APP : S_ERROR;
              end
              S_APP: step <= resp_timeout ? S_ERROR : S_OPCOND;
              S_OPCOND: begin
                if (resp_timeout) begin
                  step <= S_ERROR;
                end else if (resp.r1 == R1_IDLE) begin
                  if (retry_last) begin
                    step <= S_ERROR;
                  end else begin
                    retry_cnt <= retry_cnt + 4'd1;
                    step      <= S_APP;
                  end
                end else if (resp.r1 == R1_READY) begin
                  step <= S_OCR2;
                end else begin
                  step <= S_ERROR;
                end
              end
              S_OCR2: begin
                if (resp_timeout) begin
                  step <= S_ERROR;
                end else begin
                  // ccs bit of the ocr
                  card_hc <= resp.tail[30];
                  step    <= S_DONE;
                end
              end
              default: step <= S_ERROR;
            endcase
          end
        end
      endcase
    end
  end

endmodule

//--- verilog/sd_spi_init_top.sv
`timescale 1ns/1ps

module sd_spi_init_top import sd_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic sd_miso,
  output logic sd_sclk,
  output logic sd_mosi,
  output logic sd_cs_n,
  output logic init_done,
  output logic init_error,
  output logic card_hc,
  output logic card_v1
);

  logic        fast_sel;
  logic        sclk_rise;
  logic        sclk_fall;
  logic        cmd_start;
  logic        cmd_done;
  logic        resp_timeout;
  sd_cmd_req_s cmd_req;
  sd_resp_s    resp;

  sd_clk_gen u_clk_gen (
    .clk       (clk),
    .rst_n     (rst_n),
    .fast_sel  (fast_sel),
    .sd_sclk   (sd_sclk),
    .sclk_rise (sclk_rise),
    .sclk_fall (sclk_fall)
  );

  sd_cmd_engine u_cmd_engine (
    .clk          (clk),
    .rst_n        (rst_n),
    .sclk_rise    (sclk_rise),
    .sclk_fall    (sclk_fall),
    .cmd_start    (cmd_start),
    .cmd_req      (cmd_req),
    .sd_miso      (sd_miso),
    .sd_mosi      (sd_mosi),
    .cmd_done     (cmd_done),
    .resp_timeout (resp_timeout),
    .resp         (resp)
  );

  sd_init_fsm u_init_fsm (
    .clk          (clk),
    .rst_n        (rst_n),
    .sclk_rise    (sclk_rise),
    .cmd_done     (cmd_done),
    .resp_timeout (resp_timeout),
    .resp         (resp),
    .cmd_start    (cmd_start),
    .cmd_req      (cmd_req),
    .sd_cs_n      (sd_cs_n),
    .fast_sel     (fast_sel),
    .init_done    (init_done),
    .init_error   (init_error),
    .card_hc      (card_hc),
    .card_v1      (card_v1)
  );

endmodule

//--- sim/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk
);

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

endmodule

//--- sim/sd_card_model.sv
`timescale 1ns/1ps

module sd_card_model import sd_pkg::*; (
  input  logic       sd_sclk,
  input  logic       sd_cs_n,
  input  logic       sd_mosi,
  input  logic [3:0] cmd0_silent,
  input  logic       v1_card,
  input  logic [3:0] acmd_idle,
  input  logic       ccs,
  output logic       sd_miso,
  output int         crc_errors
);

  logic        miso_q = 1'b1;
  logic        tx_q[$];
  logic        rx_active;
  int          rx_cnt;
  logic [47:0] rx_sh;
  logic        ready;
  logic        app_next;
  int          cmd0_seen;
  int          acmd_seen;

  assign sd_miso = miso_q;

  // remainder of payload * x^7 divided by x^7 + x^3 + 1
  function automatic logic [6:0] crc7_of(input logic [39:0] payload);
    logic [46:0] rem;
    rem = {payload, 7'd0};
    for (int i = 46; i >= 7; i--) begin
      if (rem[i]) begin
        rem[i -: 8] = rem[i -: 8] ^ 8'h89;
      end
    end
    return rem[6:0];
  endfunction

  task automatic queue_bits(input logic [31:0] value, input int width);
    for (int i = width - 1; i >= 0; i--) begin
      tx_q.push_back(value[i]);
    end
  endtask

  task automatic answer(input logic [47:0] f);
    logic [5:0]  idx;
    logic [31:0] arg;
    logic        was_app;
    idx      = f[45:40];
    arg      = f[39:8];
    was_app  = app_next;
    app_next = 1'b0;
    if (f[47:46] != 2'b01 || !f[0] || f[7:1] != crc7_of(f[47:8])) begin
      crc_errors++;
    end
    // CMD0 goes out as 40 00 00 00 00 95
    if (idx == CMD_GO_IDLE && f[7:1] != 7'h4A) begin
      crc_errors++;
    end
    // one byte of Ncr gap
    queue_bits(32'hFF, 8);
    case (idx)
      CMD_GO_IDLE: begin
        if (cmd0_seen < cmd0_silent) begin
          cmd0_seen++;
        end else begin
          ready     = 1'b0;
          acmd_seen = 0;
          queue_bits(R1_IDLE, 8);
        end
      end
      CMD_SEND_IF_COND: begin
        if (v1_card) begin
          queue_bits(R1_ILLEGAL_IDLE, 8);
        end else begin
          queue_bits(R1_IDLE, 8);
          queue_bits({20'd0, arg[11:0]}, 32);
        end
      end
      CMD_READ_OCR: begin
        queue_bits(ready ? R1_READY : R1_IDLE, 8);
        // busy and ccs bits only valid once ready
        queue_bits({ready, ready & ccs, 30'h00FF_8000}, 32);
      end
      CMD_APP_CMD: begin
        app_next = 1'b1;
        queue_bits(ready ? R1_READY : R1_IDLE, 8);
      end
      CMD_SD_SEND_OP_COND: begin
        if (!was_app) begin
          queue_bits({5'd0, 1'b1, 1'b0, !ready}, 8);
        end else if (acmd_seen < acmd_idle) begin
          acmd_seen++;
          queue_bits(R1_IDLE, 8);
        end else begin
          ready = 1'b1;
          queue_bits(R1_READY, 8);
        end
      end
      default: queue_bits({5'd0, 1'b1, 1'b0, !ready}, 8);
    endcase
  endtask

  // card starts over whenever chip select is released
  always @(posedge sd_sclk or posedge sd_cs_n) begin
    if (sd_cs_n) begin
      rx_active  = 1'b0;
      rx_cnt     = 0;
      ready      = 1'b0;
      app_next   = 1'b0;
      cmd0_seen  = 0;
      acmd_seen  = 0;
      crc_errors = 0;
      tx_q.delete();
    end else if (!rx_active) begin
      if (!sd_mosi) begin
        rx_active = 1'b1;
        rx_sh     = 48'd0;
        rx_cnt    = 1;
      end
    end else begin
      rx_sh = {rx_sh[46:0], sd_mosi};
      rx_cnt++;
      if (rx_cnt == 48) begin
        rx_active = 1'b0;
        answer(rx_sh);
      end
    end
  end

  // response bits change on the falling card clock
  always @(negedge sd_sclk or posedge sd_cs_n) begin
    if (sd_cs_n || tx_q.size() == 0) begin
      miso_q <= 1'b1;
    end else begin
      miso_q <= tx_q.pop_front();
    end
  end

endmodule

//--- sim/sd_spi_init_properties.sv
`timescale 1ns/1ps

module sd_spi_init_properties import sd_pkg::*; (
  input logic       clk,
  input logic       rst_n,
  input logic       sd_cs_n,
  input logic       init_done,
  input logic       init_error,
  input logic [6:0] pwr_cnt
);

  int fail_cnt = 0;

  assert property (@(posedge clk) disable iff (!rst_n) !(init_done && init_error))
    else begin
      $error("init_done and init_error set together");
      fail_cnt++;
    end

  // chip select stays high through the power-up clocks
  assert property (@(posedge clk) disable iff (!rst_n)
    (!init_done && !init_error && pwr_cnt < POWERUP_CLOCKS - 7'd1) |-> sd_cs_n)
    else begin
      $error("sd_cs_n low during power-up wait");
      fail_cnt++;
    end

  assert property (@(posedge clk) disable iff (!rst_n) init_done |=> init_done)
    else begin
      $error("init_done dropped without reset");
      fail_cnt++;
    end

endmodule

bind sd_spi_init_top sd_spi_init_properties u_props (
  .clk        (clk),
  .rst_n      (rst_n),
  .sd_cs_n    (sd_cs_n),
  .init_done  (init_done),
  .init_error (init_error),
  .pwr_cnt    (u_init_fsm.pwr_cnt)
);

//--- sim/sd_spi_init_tb.sv
`timescale 1ns/1ps

module sd_spi_init_tb import sd_pkg::*; ();

  typedef struct packed {
    logic [3:0] cmd0_silent;
    logic       v1;
    logic [3:0] acmd_idle;
    logic       ccs;
    logic       exp_done;
    logic       exp_error;
    logic       exp_hc;
    logic       exp_v1;
  } scen_s;

  logic       clk;
  logic       rst_n = 1'b0;
  logic       sd_miso;
  logic       sd_sclk;
  logic       sd_mosi;
  logic       sd_cs_n;
  logic       init_done;
  logic       init_error;
  logic       card_hc;
  logic       card_v1;
  logic [3:0] cfg_cmd0_silent = 4'd0;
  logic       cfg_v1 = 1'b0;
  logic [3:0] cfg_acmd_idle = 4'd0;
  logic       cfg_ccs = 1'b0;
  int         crc_errors;
  scen_s      scen_tab [7];
  int         cycles = 0;
  integer     seed;

  // 7 rows, each power-up plus up to 40 slow commands with responses
  int cycle_limit = 7 * (int'(POWERUP_CLOCKS) * 2 * int'(DIV_SLOW_HALF) +
                         40 * 2 * 48 * 2 * int'(DIV_SLOW_HALF)) + 20000;

  tb_clk_gen u_clk (.clk(clk));

  sd_spi_init_top dut0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .sd_miso    (sd_miso),
    .sd_sclk    (sd_sclk),
    .sd_mosi    (sd_mosi),
    .sd_cs_n    (sd_cs_n),
    .init_done  (init_done),
    .init_error (init_error),
    .card_hc    (card_hc),
    .card_v1    (card_v1)
  );

  sd_card_model u_card (
    .sd_sclk     (sd_sclk),
    .sd_cs_n     (sd_cs_n),
    .sd_mosi     (sd_mosi),
    .cmd0_silent (cfg_cmd0_silent),
    .v1_card     (cfg_v1),
    .acmd_idle   (cfg_acmd_idle),
    .ccs         (cfg_ccs),
    .sd_miso     (sd_miso),
    .crc_errors  (crc_errors)
  );

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got == exp) else begin
      stop_run($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
  endtask

  // falling clk edges seen during one sd_sclk level
  task automatic measure_sclk_half(output int clocks);
    logic lvl;
    clocks = 0;
    // let a pending rate change land first
    repeat (2) begin
      lvl = sd_sclk;
      while (sd_sclk == lvl) begin
        @(negedge clk);
      end
    end
    lvl = sd_sclk;
    while (sd_sclk == lvl) begin
      clocks++;
      @(negedge clk);
    end
  endtask

  always @(negedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      stop_run("timeout, neither init_done nor init_error came within the cycle limit");
    end
  end

  // a failed bound assertion ends the run at once
  always @(negedge clk) begin
    if (dut0.u_props.fail_cnt != 0) begin
      stop_run("a bound assertion on the DUT failed");
    end
  end

  initial begin
    scen_s row;
    int    half;
    int    exp_half;
    int    rnd_idle;
    seed = 32'h2157;
    rnd_idle = $unsigned($random(seed)) % 10;
    //                cmd0  v1    acmd  ccs   done  err   hc    v1
    scen_tab[0] = '{4'd0,  1'b0, 4'd3,  1'b1, 1'b1, 1'b0, 1'b1, 1'b0};
    scen_tab[1] = '{4'd0,  1'b0, 4'd3,  1'b0, 1'b1, 1'b0, 1'b0, 1'b0};
    scen_tab[2] = '{4'd0,  1'b1, 4'd2,  1'b0, 1'b1, 1'b0, 1'b0, 1'b1};
    scen_tab[3] = '{4'd2,  1'b0, 4'd1,  1'b1, 1'b1, 1'b0, 1'b1, 1'b0};
    scen_tab[4] = '{4'd15, 1'b0, 4'd0,  1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
    scen_tab[5] = '{4'd0,  1'b0, 4'd10, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0};
    scen_tab[6] = '{4'd0,  1'b0, 4'(rnd_idle), 1'b1, 1'b1, 1'b0, 1'b1, 1'b0};

    for (int i = 0; i < 7; i++) begin
      row = scen_tab[i];
      @(negedge clk);
      cfg_cmd0_silent = row.cmd0_silent;
      cfg_v1          = row.v1;
      cfg_acmd_idle   = row.acmd_idle;
      cfg_ccs         = row.ccs;
      apply_reset();
      while (!(init_done || init_error)) begin
        @(negedge clk);
      end
      $display("scenario %0d ended, done=%0b error=%0b hc=%0b v1=%0b",
               i, init_done, init_error, card_hc, card_v1);
      check_value("init_done", init_done, row.exp_done);
      check_value("init_error", init_error, row.exp_error);
      check_value("card_hc", card_hc, row.exp_hc);
      check_value("card_v1", card_v1, row.exp_v1);
      check_value("card model crc_errors", crc_errors, 0);
      exp_half = row.exp_done ? int'(DIV_FAST_HALF) : int'(DIV_SLOW_HALF);
      measure_sclk_half(half);
      check_value("sd_sclk half period", half, exp_half);
      // levels hold after the result
      check_value("init_done held", init_done, row.exp_done);
      check_value("init_error held", init_error, row.exp_error);
    end

    if (dut0.u_props.fail_cnt == 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      stop_run("bound assertions failed during the run");
    end
  end

endmodule

//--- src.f
verilog/sd_pkg.sv
verilog/sd_clk_gen.sv
verilog/sd_cmd_engine.sv
verilog/sd_init_fsm.sv
verilog/sd_spi_init_top.sv
sim/tb_clk_gen.sv
sim/sd_card_model.sv
sim/sd_spi_init_properties.sv
sim/sd_spi_init_tb.sv

//--- Bender.yml
package:
  name: sd_spi_init

sources:
  - verilog/sd_pkg.sv
  - verilog/sd_clk_gen.sv
  - verilog/sd_cmd_engine.sv
  - verilog/sd_init_fsm.sv
  - verilog/sd_spi_init_top.sv
  - target: simulation
    files:
      - sim/tb_clk_gen.sv
      - sim/sd_card_model.sv
      - sim/sd_spi_init_properties.sv
      - sim/sd_spi_init_tb.sv
